//--- common/core_macros.svh
// register map, readback selectors and sizing of the bus-clock core
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// settings bus register offsets
`define CORE_SR_READBACK   32'd0
`define CORE_SR_MISC       32'd4
`define CORE_SR_TEST       32'd28
`define CORE_SR_RX_PKT_LEN 32'd36
// any data written here clears the sticky status bits
`define CORE_SR_CLEAR      32'd40

// readback selectors
`define CORE_RB_MISC   5'd1
`define CORE_RB_COMPAT 5'd2
`define CORE_RB_PLL    5'd4
`define CORE_RB_STATUS 5'd6
`define CORE_RB_TEST   5'd24

// fixed readback words
`define CORE_COMPAT_WORD 32'hAC000B00
`define CORE_RB_DEFAULT  32'hdeadbeef

// buffer size of both packet FIFOs
`define CORE_FIFO_DEPTH_LOG2 4

`endif

//--- common/core_pkg.sv
// shared types for the bus-clock core
// beat payloads of both FIFOs and the readback word
`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////
  // stream payloads
  //////////////////////////////////////////////////

  // host transmit beat
  // first sample in bits 31:0, second in bits 63:32
  typedef logic [63:0] tx_beat_t;

  // receive beat toward the host
  // last flags the final beat of a packet
  typedef struct packed {
    logic        last;
    logic [63:0] data;
  } rx_beat_t;

  //////////////////////////////////////////////////
  // settings readback
  //////////////////////////////////////////////////

  // one word returned by the readback mux
  typedef logic [31:0] rb_word_t;

endpackage

`default_nettype wire

//--- hw/core_settings.sv
// global settings block of the bus-clock core
// registers, pll lock synchronizer, sticky clear and readback mux
`timescale 1ns/1ns
`default_nettype none
`include "core_macros.svh"

module core_settings (
  input  wire                bus_clk,
  input  wire                bus_rst,
  // settings bus
  input  wire                i_set_stb,
  input  wire [31:0]         i_set_addr,
  input  wire [31:0]         i_set_data,
  // status inputs
  input  wire [3:0]          i_tcxo_status,
  input  wire [1:0]          i_lock_signals,
  input  wire                i_rx_overflow,
  input  wire                i_tx_underrun,
  // readback and control outputs
  output core_pkg::rb_word_t o_rb_data,
  output wire [1:0]          o_pps_select,
  output wire                o_mimo,
  output wire                o_codec_arst,
  output wire [2:0]          o_tx_bandsel,
  output wire [5:0]          o_rx_bandsel_a,
  output wire [3:0]          o_rx_bandsel_b,
  output wire [3:0]          o_rx_bandsel_c,
  output logic [7:0]         o_rx_pkt_len,
  output logic               o_status_clr
);

  logic [4:0]  rb_addr;
  logic [20:0] misc_reg;
  logic [31:0] test_reg;
  logic [1:0]  lock_meta;
  logic [1:0]  lock_sync;

  //////////////////////////////////////////////////
  // settings registers
  //////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rb_addr      <= 5'd0;
      // internal pps selected out of reset
      misc_reg     <= 21'd2;
      test_reg     <= 32'd0;
      o_rx_pkt_len <= 8'd4;
      o_status_clr <= 1'b0;
    end else begin
      // one-cycle pulse per clear write
      o_status_clr <= i_set_stb && (i_set_addr == `CORE_SR_CLEAR);
      if (i_set_stb) begin
        case (i_set_addr)
          `CORE_SR_READBACK:   rb_addr      <= i_set_data[4:0];
          `CORE_SR_MISC:       misc_reg     <= i_set_data[20:0];
          `CORE_SR_TEST:       test_reg     <= i_set_data;
          `CORE_SR_RX_PKT_LEN: o_rx_pkt_len <= i_set_data[7:0];
          default: ;
        endcase
      end
    end
  end

  // misc register fields
  assign o_pps_select   = misc_reg[1:0];
  assign o_mimo         = misc_reg[2];
  assign o_codec_arst   = misc_reg[3];
  assign o_tx_bandsel   = misc_reg[6:4];
  assign o_rx_bandsel_a = misc_reg[12:7];
  assign o_rx_bandsel_b = misc_reg[16:13];
  assign o_rx_bandsel_c = misc_reg[20:17];

  // two flops on the asynchronous pll locks
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////////////////////////
  // readback mux
  //////////////////////////////////////////////////

  always_comb begin
    case (rb_addr)
      `CORE_RB_MISC:   o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      `CORE_RB_COMPAT: o_rb_data = `CORE_COMPAT_WORD;
      `CORE_RB_PLL:    o_rb_data = {30'd0, lock_sync};
      `CORE_RB_STATUS: o_rb_data = {30'd0, i_tx_underrun, i_rx_overflow};
      `CORE_RB_TEST:   o_rb_data = test_reg;
      default:         o_rb_data = `CORE_RB_DEFAULT;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pkt_fifo.sv
// synchronous FIFO with valid/ready handshake on both sides
// circular buffer, payload type set per instance
`timescale 1ns/1ns
`default_nettype none

module pkt_fifo #(
  parameter type T          = logic [63:0],
  parameter int  DEPTH_LOG2 = 4
) (
  input  wire   bus_clk,
  input  wire   bus_rst,
  // write side
  input  wire T i_data,
  input  wire   i_valid,
  output logic  o_ready,
  // read side
  output T      o_data,
  output logic  o_valid,
  input  wire   i_ready
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  T                      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  // top count bit alone marks a full buffer
  assign o_ready = !count[DEPTH_LOG2];
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // storage
  always_ff @(posedge bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- radio/radio_rx_framer.sv
// receive framer, packs pairs of radio samples into host beats
// flags the last beat of each packet and a sticky overflow
`timescale 1ns/1ns
`default_nettype none

module radio_rx_framer (
  input  wire                bus_clk,
  input  wire                bus_rst,
  input  wire                i_rx_stb,
  input  wire [31:0]         i_rx_data,
  input  wire [7:0]          i_pkt_len,
  input  wire                i_status_clr,
  input  wire                i_ready,
  output core_pkg::rx_beat_t o_beat,
  output logic               o_valid,
  output logic               o_overflow
);

  import core_pkg::*;

  logic [31:0] lo_sample;
  logic        half;
  logic [7:0]  beat_cnt;
  logic [7:0]  last_idx;
  logic        pkt_end;

  // a length of zero acts as one beat per packet
  assign last_idx = (i_pkt_len == 8'd0) ? 8'd0 : i_pkt_len - 8'd1;
  assign pkt_end  = (beat_cnt >= last_idx);

  // first sample of the pair waits here
  always_ff @(posedge bus_clk) begin
    if (i_rx_stb && !half) begin
      lo_sample <= i_rx_data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (i_rx_stb && half) begin
      o_beat <= rx_beat_t'{last: pkt_end, data: {i_rx_data, lo_sample}};
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      half     <= 1'b0;
      beat_cnt <= 8'd0;
      o_valid  <= 1'b0;
    end else begin
      // valid lasts one cycle, no retry
      o_valid <= i_rx_stb && half;
      if (i_rx_stb) begin
        half <= !half;
        if (half) begin
          beat_cnt <= pkt_end ? 8'd0 : beat_cnt + 8'd1;
        end
      end
    end
  end

  // beat refused by the FIFO is lost
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_overflow <= 1'b0;
    end else if (o_valid && !i_ready) begin
      o_overflow <= 1'b1;
    end else if (i_status_clr) begin
      o_overflow <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- radio/radio_tx_sampler.sv
// transmit sampler, hands one 32-bit sample to the radio per strobe
// low half of each beat first, sticky underrun on an empty FIFO
`timescale 1ns/1ns
`default_nettype none

module radio_tx_sampler (
  input  wire                     bus_clk,
  input  wire                     bus_rst,
  input  wire                     i_tx_stb,
  input  wire core_pkg::tx_beat_t i_beat,
  input  wire                     i_valid,
  input  wire                     i_status_clr,
  output logic                    o_ready,
  output logic [31:0]             o_tx_data,
  output logic                    o_underrun
);

  logic half;
  logic take;

  assign take = i_tx_stb && i_valid;

  // pop together with the high-half sample
  assign o_ready = take && half;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      half      <= 1'b0;
      o_tx_data <= 32'd0;
    end else if (i_tx_stb) begin
      if (i_valid) begin
        o_tx_data <= half ? i_beat[63:32] : i_beat[31:0];
        half      <= !half;
      end else begin
        // nothing buffered so send silence
        o_tx_data <= 32'd0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_underrun <= 1'b0;
    end else if (i_tx_stb && !i_valid) begin
      o_underrun <= 1'b1;
    end else if (i_status_clr) begin
      o_underrun <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/core_top.sv
// bus-clock core top level
// settings block, transmit and receive FIFOs and the radio framing blocks
`timescale 1ns/1ns
`default_nettype none
`include "core_macros.svh"

module core_top (
  input  wire                     bus_clk,
  input  wire                     bus_rst,
  // settings bus
  input  wire                     i_set_stb,
  input  wire [31:0]              i_set_addr,
  input  wire [31:0]              i_set_data,
  // host to radio stream
  input  wire [63:0]              i_h2s_tdata,
  input  wire                     i_h2s_tvalid,
  output wire                     o_h2s_tready,
  // radio to host stream
  output wire [63:0]              o_s2h_tdata,
  output wire                     o_s2h_tlast,
  output wire                     o_s2h_tvalid,
  input  wire                     i_s2h_tready,
  // radio strobes and samples
  input  wire                     i_rx_stb,
  input  wire [31:0]              i_rx_data,
  input  wire                     i_tx_stb,
  output wire [31:0]              o_tx_data,
  // board status
  input  wire [3:0]               i_tcxo_status,
  input  wire [1:0]               i_lock_signals,
  // readback and board controls
  output wire core_pkg::rb_word_t o_rb_data,
  output wire [1:0]               o_pps_select,
  output wire                     o_mimo,
  output wire                     o_codec_arst,
  output wire [2:0]               o_tx_bandsel,
  output wire [5:0]               o_rx_bandsel_a,
  output wire [3:0]               o_rx_bandsel_b,
  output wire [3:0]               o_rx_bandsel_c
);

  import core_pkg::*;

  wire tx_beat_t tx_beat;
  wire           tx_valid;
  wire           tx_ready;
  wire rx_beat_t rx_beat;
  wire           rx_valid;
  wire           rx_ready;
  wire rx_beat_t s2h_beat;
  wire [7:0]     rx_pkt_len;
  wire           status_clr;
  wire           rx_overflow;
  wire           tx_underrun;

  //////////////////////////////////////////////////
  // global settings
  //////////////////////////////////////////////////

  core_settings settings (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_tcxo_status  (i_tcxo_status),
    .i_lock_signals (i_lock_signals),
    .i_rx_overflow  (rx_overflow),
    .i_tx_underrun  (tx_underrun),
    .o_rb_data      (o_rb_data),
    .o_pps_select   (o_pps_select),
    .o_mimo         (o_mimo),
    .o_codec_arst   (o_codec_arst),
    .o_tx_bandsel   (o_tx_bandsel),
    .o_rx_bandsel_a (o_rx_bandsel_a),
    .o_rx_bandsel_b (o_rx_bandsel_b),
    .o_rx_bandsel_c (o_rx_bandsel_c),
    .o_rx_pkt_len   (rx_pkt_len),
    .o_status_clr   (status_clr)
  );

  //////////////////////////////////////////////////
  // transmit chain
  //////////////////////////////////////////////////

  // host last flag is not carried to the radio
  pkt_fifo #(.T(tx_beat_t), .DEPTH_LOG2(`CORE_FIFO_DEPTH_LOG2)) tx_fifo (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_data  (i_h2s_tdata),
    .i_valid (i_h2s_tvalid),
    .o_ready (o_h2s_tready),
    .o_data  (tx_beat),
    .o_valid (tx_valid),
    .i_ready (tx_ready)
  );

  radio_tx_sampler tx_sampler (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_tx_stb     (i_tx_stb),
    .i_beat       (tx_beat),
    .i_valid      (tx_valid),
    .i_status_clr (status_clr),
    .o_ready      (tx_ready),
    .o_tx_data    (o_tx_data),
    .o_underrun   (tx_underrun)
  );

  //////////////////////////////////////////////////
  // receive chain
  //////////////////////////////////////////////////

  radio_rx_framer rx_framer (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_rx_stb     (i_rx_stb),
    .i_rx_data    (i_rx_data),
    .i_pkt_len    (rx_pkt_len),
    .i_status_clr (status_clr),
    .i_ready      (rx_ready),
    .o_beat       (rx_beat),
    .o_valid      (rx_valid),
    .o_overflow   (rx_overflow)
  );

  pkt_fifo #(.T(rx_beat_t), .DEPTH_LOG2(`CORE_FIFO_DEPTH_LOG2)) rx_fifo (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_data  (rx_beat),
    .i_valid (rx_valid),
    .o_ready (rx_ready),
    .o_data  (s2h_beat),
    .o_valid (o_s2h_tvalid),
    .i_ready (i_s2h_tready)
  );

  assign o_s2h_tdata = s2h_beat.data;
  assign o_s2h_tlast = s2h_beat.last;

endmodule

`default_nettype wire

//--- test/core_props.sv
// stream handshake properties of the bus-clock core
// bound to every pkt_fifo and to the host stream of core_top
`timescale 1ns/1ns
`default_nettype none
`include "core_macros.svh"

module core_props #(
  parameter int W  = 64,
  parameter int LW = 5
) (
  input wire          clk,
  input wire          rst,
  input wire          in_valid,
  input wire          in_ready,
  input wire [LW-1:0] level,
  input wire          out_valid,
  input wire          out_ready,
  input wire [W-1:0]  out_data
);

  // output holds its beat until it is taken
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("stream output changed before its transfer");

  // a full buffer takes nothing in
  a_no_write: assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> level <= $past(level))
    else $error("write accepted while ready was low");

  a_reset_idle: assert property (@(posedge clk)
    rst |=> !out_valid)
    else $error("valid high in the cycle after reset");

endmodule

//////////////////////////////////////////////////
// bindings
//////////////////////////////////////////////////

bind pkt_fifo core_props #(.W($bits(o_data)), .LW($bits(count))) fifo_props (
  .clk       (bus_clk),
  .rst       (bus_rst),
  .in_valid  (i_valid),
  .in_ready  (o_ready),
  .level     (count),
  .out_valid (o_valid),
  .out_ready (i_ready),
  .out_data  (o_data)
);

// host writes measured against the transmit FIFO occupancy
bind core_top core_props #(.W(65), .LW(`CORE_FIFO_DEPTH_LOG2 + 1)) s2h_props (
  .clk       (bus_clk),
  .rst       (bus_rst),
  .in_valid  (i_h2s_tvalid),
  .in_ready  (o_h2s_tready),
  .level     (tx_fifo.count),
  .out_valid (o_s2h_tvalid),
  .out_ready (i_s2h_tready),
  .out_data  ({o_s2h_tlast, o_s2h_tdata})
);

`default_nettype wire

//--- test/tb_core_top.sv
// testbench for the bus-clock core
// replays the command file against the DUT and checks every response
`timescale 1ns/1ns
`default_nettype none
`include "core_macros.svh"

module tb_core_top;

  import core_pkg::*;

  logic             bus_clk;
  logic             bus_rst;
  logic             i_set_stb;
  logic [31:0]      i_set_addr;
  logic [31:0]      i_set_data;
  logic [63:0]      i_h2s_tdata;
  logic             i_h2s_tvalid;
  logic             i_s2h_tready = 1'b0;
  logic             i_rx_stb;
  logic [31:0]      i_rx_data;
  logic             i_tx_stb;
  logic [3:0]       i_tcxo_status;
  logic [1:0]       i_lock_signals;
  wire              o_h2s_tready;
  wire  [63:0]      o_s2h_tdata;
  wire              o_s2h_tlast;
  wire              o_s2h_tvalid;
  wire  [31:0]      o_tx_data;
  rb_word_t         o_rb_data;
  wire  [1:0]       o_pps_select;
  wire              o_mimo;
  wire              o_codec_arst;
  wire  [2:0]       o_tx_bandsel;
  wire  [5:0]       o_rx_bandsel_a;
  wire  [3:0]       o_rx_bandsel_b;
  wire  [3:0]       o_rx_bandsel_c;

  rx_beat_t         rx_got [$];
  int               fd;
  int               cur_test;
  int               tests;
  int               checks;
  int               errors;
  int               test_errors;
  int               ready_mode;
  int unsigned      cycles = 0;
  int unsigned      limit = 0;
  logic [8*160-1:0] text_line;

  core_top dut (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_h2s_tdata    (i_h2s_tdata),
    .i_h2s_tvalid   (i_h2s_tvalid),
    .o_h2s_tready   (o_h2s_tready),
    .o_s2h_tdata    (o_s2h_tdata),
    .o_s2h_tlast    (o_s2h_tlast),
    .o_s2h_tvalid   (o_s2h_tvalid),
    .i_s2h_tready   (i_s2h_tready),
    .i_rx_stb       (i_rx_stb),
    .i_rx_data      (i_rx_data),
    .i_tx_stb       (i_tx_stb),
    .o_tx_data      (o_tx_data),
    .i_tcxo_status  (i_tcxo_status),
    .i_lock_signals (i_lock_signals),
    .o_rb_data      (o_rb_data),
    .o_pps_select   (o_pps_select),
    .o_mimo         (o_mimo),
    .o_codec_arst   (o_codec_arst),
    .o_tx_bandsel   (o_tx_bandsel),
    .o_rx_bandsel_a (o_rx_bandsel_a),
    .o_rx_bandsel_b (o_rx_bandsel_b),
    .o_rx_bandsel_c (o_rx_bandsel_c)
  );

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
  end

  //////////////////////////////////////////////////
  // host side of the receive stream
  //////////////////////////////////////////////////

  // ready is set here and the beat taken at the next rising edge
  always @(negedge bus_clk) begin
    if (bus_rst) begin
      i_s2h_tready = 1'b0;
    end else begin
      case (ready_mode)
        0:       i_s2h_tready = 1'b0;
        1:       i_s2h_tready = (($urandom % 4) != 0);
        default: i_s2h_tready = 1'b1;
      endcase
      if (o_s2h_tvalid && i_s2h_tready) begin
        rx_got.push_back(rx_beat_t'{last: o_s2h_tlast, data: o_s2h_tdata});
      end
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  function automatic void record_check(input bit ok);
    checks++;
    if (!ok) begin
      errors++;
      test_errors++;
    end
  endfunction

  task automatic check_rb(input rb_word_t got, input rb_word_t exp, input logic [4:0] sel);
    record_check(got == exp);
    if (got != exp) begin
      $display("FAIL t=%0t test %0d: readback sel %0d got %h expected %h",
               $time, cur_test, sel, got, exp);
    end
  endtask

  task automatic check_tx(input logic [31:0] got, input logic [31:0] exp);
    record_check(got == exp);
    if (got != exp) begin
      $display("FAIL t=%0t test %0d: tx sample got %h expected %h",
               $time, cur_test, got, exp);
    end
  endtask

  task automatic check_s2h(input rx_beat_t got, input rx_beat_t exp);
    record_check(got == exp);
    if (got != exp) begin
      $display("FAIL t=%0t test %0d: s2h beat got last=%b data=%h expected last=%b data=%h",
               $time, cur_test, got.last, got.data, exp.last, exp.data);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    record_check(got === exp);
    if (got !== exp) begin
      $display("FAIL t=%0t test %0d: %s got %b expected %b",
               $time, cur_test, what, got, exp);
    end
  endtask

  task automatic check_field(input logic [1:0] pps, input logic mimo, input logic arst,
                             input logic [2:0] txb, input logic [5:0] rxa,
                             input logic [3:0] rxb, input logic [3:0] rxc);
    logic ok;
    ok = (o_pps_select == pps) && (o_mimo == mimo) && (o_codec_arst == arst) &&
         (o_tx_bandsel == txb) && (o_rx_bandsel_a == rxa) &&
         (o_rx_bandsel_b == rxb) && (o_rx_bandsel_c == rxc);
    record_check(ok);
    if (!ok) begin
      $display("FAIL t=%0t test %0d: misc got %h %b %b %h %h %h %h exp %h %b %b %h %h %h %h",
               $time, cur_test, o_pps_select, o_mimo, o_codec_arst, o_tx_bandsel,
               o_rx_bandsel_a, o_rx_bandsel_b, o_rx_bandsel_c,
               pps, mimo, arst, txb, rxa, rxb, rxc);
    end
  endtask

  //////////////////////////////////////////////////
  // bus and stream drivers
  //////////////////////////////////////////////////

  task automatic set_write(input logic [31:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge bus_clk);
    i_set_stb  = 1'b0;
  endtask

  // selector write, then the word is valid a cycle later
  task automatic readback_expect(input logic [4:0] sel, input rb_word_t exp);
    set_write(`CORE_SR_READBACK, {27'd0, sel});
    check_rb(o_rb_data, exp, sel);
  endtask

  task automatic host_push(input tx_beat_t beat);
    i_h2s_tdata  = beat;
    i_h2s_tvalid = 1'b1;
    while (!o_h2s_tready) begin
      @(negedge bus_clk);
    end
    @(negedge bus_clk);
    i_h2s_tvalid = 1'b0;
  endtask

  task automatic tx_strobe(input logic [31:0] exp);
    i_tx_stb = 1'b1;
    @(negedge bus_clk);
    i_tx_stb = 1'b0;
    check_tx(o_tx_data, exp);
  endtask

  // back to back samples counting up from base
  task automatic rx_samples(input int n, input logic [31:0] base);
    for (int i = 0; i < n; i++) begin
      i_rx_stb  = 1'b1;
      i_rx_data = base + i;
      @(negedge bus_clk);
    end
    i_rx_stb = 1'b0;
  endtask

  task automatic expect_beat(input rx_beat_t exp);
    rx_beat_t got;
    while (rx_got.size() == 0) begin
      @(negedge bus_clk);
    end
    got = rx_got.pop_front();
    check_s2h(got, exp);
  endtask

  // two sync flops plus a cycle of margin
  task automatic set_locks(input logic [1:0] locks);
    i_lock_signals = locks;
    repeat (3) @(negedge bus_clk);
  endtask

  //////////////////////////////////////////////////
  // command file
  //////////////////////////////////////////////////

  task automatic count_file_lines();
    int lines;
    int cfd;
    lines = 0;
    cfd = $fopen("test/core_input.txt", "r");
    if (cfd != 0) begin
      while (!$feof(cfd)) begin
        if ($fgets(text_line, cfd) != 0) begin
          lines++;
        end
      end
      $fclose(cfd);
    end
    limit = lines * 64;
  endtask

  task automatic run_commands();
    logic [7:0]  tag;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] fv [0:6];
    int          n;
    int          code;
    while ($fscanf(fd, " %c", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(text_line, fd);
      end else begin
        code = $fscanf(fd, "%d", cur_test);
        case (tag)
          "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            set_write(a[31:0], b[31:0]);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            readback_expect(a[4:0], b[31:0]);
          end
          "F": begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h",
                           fv[0], fv[1], fv[2], fv[3], fv[4], fv[5], fv[6]);
            check_field(fv[0][1:0], fv[1][0], fv[2][0], fv[3][2:0],
                        fv[4][5:0], fv[5][3:0], fv[6][3:0]);
          end
          "H": begin
            code = $fscanf(fd, "%h", a);
            host_push(a);
          end
          "S": begin
            code = $fscanf(fd, "%h", a);
            tx_strobe(a[31:0]);
          end
          "X": begin
            code = $fscanf(fd, "%d %h", n, a);
            rx_samples(n, a[31:0]);
          end
          "Q": begin
            code = $fscanf(fd, "%h %h", a, b);
            expect_beat(rx_beat_t'{last: b[0], data: a});
          end
          "M": begin
            code = $fscanf(fd, "%d", ready_mode);
          end
          "L": begin
            code = $fscanf(fd, "%h", a);
            set_locks(a[1:0]);
          end
          "E": begin
            $display("test %0d done with %0d errors", cur_test, test_errors);
            tests++;
            test_errors = 0;
          end
          default: begin
            $display("unknown command tag %c in the command file", tag);
            errors++;
          end
        endcase
      end
    end
  endtask

  initial begin
    void'($urandom(32'hb63c_9ef0));
    bus_rst        = 1'b1;
    i_set_stb      = 1'b0;
    i_set_addr     = 32'd0;
    i_set_data     = 32'd0;
    i_h2s_tdata    = 64'd0;
    i_h2s_tvalid   = 1'b0;
    i_rx_stb       = 1'b0;
    i_rx_data      = 32'd0;
    i_tx_stb       = 1'b0;
    i_tcxo_status  = 4'ha;
    i_lock_signals = 2'b00;
    ready_mode     = 2;
    tests          = 0;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    cur_test       = 0;
    count_file_lines();
    repeat (10) @(negedge bus_clk);
    bus_rst = 1'b0;
    // both streams come out of reset idle
    check_flag("h2s tready", o_h2s_tready, 1'b1);
    check_flag("s2h tvalid", o_s2h_tvalid, 1'b0);
    $display("reset test done with %0d errors", test_errors);
    tests++;
    test_errors = 0;
    fd = $fopen("test/core_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the command file test/core_input.txt");
      $display("test failed");
      $finish;
    end else begin
      run_commands();
      $fclose(fd);
      if (rx_got.size() != 0) begin
        $display("%0d unexpected beats left on the host stream", rx_got.size());
        errors++;
      end
      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // watchdog sized from the command file length
  initial begin
    wait (limit != 0);
    wait (cycles >= limit);
    $display("timeout: the commands did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/core_input.txt
# columns: tag, test number, then hex fields (the X count is decimal)
# W addr data | R sel expect | F pps mimo arst txb rxa rxb rxc | H beat | S sample
# X count first_sample | Q beat last | M s2h ready mode | L locks | E end of test
R 1 18 00000000
R 1 02 ac000b00
R 1 01 0000002a
R 1 07 deadbeef
F 1 2 0 0 0 0 0 0
E 1
W 2 04 000d3555
F 2 1 1 0 5 2a 9 6
R 2 01 00000029
W 2 1c 5a5a1234
R 2 18 5a5a1234
E 2
H 3 bbbb0001aaaa0001
H 3 bbbb0002aaaa0002
S 3 aaaa0001
S 3 bbbb0001
S 3 aaaa0002
S 3 bbbb0002
S 3 00000000
R 3 06 00000002
W 3 28 00000000
R 3 06 00000000
E 3
W 4 24 00000003
M 4 1
X 4 12 10000000
Q 4 1000000110000000 0
Q 4 1000000310000002 0
Q 4 1000000510000004 1
Q 4 1000000710000006 0
Q 4 1000000910000008 0
Q 4 1000000b1000000a 1
R 4 06 00000000
E 4
W 5 24 00000005
M 5 0
X 5 40 20000000
R 5 06 00000001
M 5 2
Q 5 2000000120000000 0
Q 5 2000000320000002 0
Q 5 2000000520000004 0
Q 5 2000000720000006 0
Q 5 2000000920000008 1
Q 5 2000000b2000000a 0
Q 5 2000000d2000000c 0
Q 5 2000000f2000000e 0
Q 5 2000001120000010 0
Q 5 2000001320000012 1
Q 5 2000001520000014 0
Q 5 2000001720000016 0
Q 5 2000001920000018 0
Q 5 2000001b2000001a 0
Q 5 2000001d2000001c 1
Q 5 2000001f2000001e 0
E 5
L 6 1
R 6 04 00000001
L 6 2
R 6 04 00000002
L 6 3
R 6 04 00000003
S 6 00000000
R 6 06 00000003
W 6 28 00000000
R 6 06 00000000
E 6

//--- compile.f
+incdir+common
common/core_pkg.sv
hw/core_settings.sv
hw/pkt_fifo.sv
radio/radio_rx_framer.sv
radio/radio_tx_sampler.sv
hw/core_top.sv
test/core_props.sv
test/tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bus-clock core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core_top \
  -f compile.f --Mdir obj_dir -o tb_core_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_core_top_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
echo "pass line not found in the simulation output"
exit 1
